//--- rtl/rename_consts.svh
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// register index widths
`define ARF_WIDTH     5
`define PRF_WIDTH     6

// table and pool sizes
`define NUM_ARF       32   // architectural regs, alias table depth
`define NUM_PRF       64   // physical regs, also free list depth

// slots per cycle
`define GROUP_WIDTH   4    // renamed per cycle
`define RETIRE_WIDTH  4    // released per cycle

`endif

//--- rtl/rename_pkg.sv
`include "rename_consts.svh"

package rename_pkg;

    typedef logic [`ARF_WIDTH-1:0]   areg_t;      // architectural index
    typedef logic [`PRF_WIDTH-1:0]   preg_t;      // physical index
    typedef logic [`GROUP_WIDTH-1:0] slot_mask_t; // one bit per slot

    // free list pointer, depth is a power of two so it wraps on its own
    typedef logic [`PRF_WIDTH-1:0]   fl_ptr_t;

    // where a renamed field gets its physical number from
    typedef enum logic [1:0] {
        SRC_TABLE = 2'd0,  // alias table read
        SRC_SLOT0 = 2'd1,  // new dest of slot 0
        SRC_SLOT1 = 2'd2,
        SRC_SLOT2 = 2'd3
    } src_sel_e;

endpackage

//--- rtl/rename_group_if.sv
`timescale 1ns/10ps
`include "rename_consts.svh"

// logical register fields of one rename group
interface rename_group_if;

    rename_pkg::areg_t      rs1 [`GROUP_WIDTH];  // source 1 per slot
    rename_pkg::areg_t      rs2 [`GROUP_WIDTH];  // source 2 per slot
    rename_pkg::areg_t      rd  [`GROUP_WIDTH];  // destination per slot
    rename_pkg::slot_mask_t rs1_v;
    rename_pkg::slot_mask_t rs2_v;
    rename_pkg::slot_mask_t rd_v;

    // decode side
    modport src (
        output rs1,
        output rs2,
        output rd,
        output rs1_v,
        output rs2_v,
        output rd_v
    );

    // rename side
    modport dst (
        input rs1,
        input rs2,
        input rd,
        input rs1_v,
        input rs2_v,
        input rd_v
    );

endinterface

//--- rtl/rename_resolve.sv
`timescale 1ns/10ps
`include "rename_consts.svh"

module rename_resolve (
    rename_group_if.dst            grp,
    input  rename_pkg::preg_t      tbl_rs1   [`GROUP_WIDTH],  // alias table reads
    input  rename_pkg::preg_t      tbl_rs2   [`GROUP_WIDTH],
    input  rename_pkg::preg_t      tbl_rd    [`GROUP_WIDTH],
    input  rename_pkg::preg_t      head_preg [`GROUP_WIDTH],  // free list head..head+3
    output rename_pkg::preg_t      prs1      [`GROUP_WIDTH],
    output rename_pkg::preg_t      prs2      [`GROUP_WIDTH],
    output rename_pkg::preg_t      prd       [`GROUP_WIDTH],
    output rename_pkg::preg_t      preprd    [`GROUP_WIDTH],
    output rename_pkg::slot_mask_t tbl_we
);

    rename_pkg::src_sel_e sel_rs1 [`GROUP_WIDTH];
    rename_pkg::src_sel_e sel_rs2 [`GROUP_WIDTH];
    rename_pkg::src_sel_e sel_rd  [`GROUP_WIDTH];

    // final mux for one field
    function automatic rename_pkg::preg_t pick(
        input rename_pkg::src_sel_e sel,
        input rename_pkg::preg_t    tbl,
        input rename_pkg::preg_t    alloc [`GROUP_WIDTH]
    );
        rename_pkg::preg_t res;
        case (sel)
            rename_pkg::SRC_SLOT0: res = alloc[0];
            rename_pkg::SRC_SLOT1: res = alloc[1];
            rename_pkg::SRC_SLOT2: res = alloc[2];
            default:               res = tbl;
        endcase
        return res;
    endfunction

    // k-th valid dest takes head+k, invalid slots skipped
    always_comb begin : alloc_p
        logic [1:0] rank;
        rank = '0;
        for (int i = 0; i < `GROUP_WIDTH; i++) begin
            prd[i] = head_preg[rank];       // don't-care when rd_v[i] low
            rank   = rank + 2'(grp.rd_v[i]);
        end
    end

    // raw / waw against earlier slots, later j overrides so nearest wins
    always_comb begin
        for (int i = 0; i < `GROUP_WIDTH; i++) begin
            sel_rs1[i] = rename_pkg::SRC_TABLE;
            sel_rs2[i] = rename_pkg::SRC_TABLE;
            sel_rd[i]  = rename_pkg::SRC_TABLE;
            for (int j = 0; j < i; j++) begin
                if (grp.rd_v[j] && grp.rs1_v[i] && grp.rd[j] == grp.rs1[i])
                    sel_rs1[i] = rename_pkg::src_sel_e'(2'(j + 1));
                if (grp.rd_v[j] && grp.rs2_v[i] && grp.rd[j] == grp.rs2[i])
                    sel_rs2[i] = rename_pkg::src_sel_e'(2'(j + 1));
                if (grp.rd_v[j] && grp.rd_v[i] && grp.rd[j] == grp.rd[i])
                    sel_rd[i] = rename_pkg::src_sel_e'(2'(j + 1));  // old map from older dest
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `GROUP_WIDTH; i++) begin
            prs1[i]   = pick(sel_rs1[i], tbl_rs1[i], prd);
            prs2[i]   = pick(sel_rs2[i], tbl_rs2[i], prd);
            preprd[i] = pick(sel_rd[i], tbl_rd[i], prd);
        end
    end

    // youngest writer per arch reg updates the table
    always_comb begin
        for (int i = 0; i < `GROUP_WIDTH; i++) begin
            tbl_we[i] = grp.rd_v[i];
            for (int j = i + 1; j < `GROUP_WIDTH; j++) begin
                if (grp.rd_v[j] && grp.rd[j] == grp.rd[i])
                    tbl_we[i] = 1'b0;  // overwritten later in group
            end
        end
    end

endmodule

//--- rtl/rename_map_table.sv
`timescale 1ns/10ps
`include "rename_consts.svh"

module rename_map_table (
    input  logic                   clk,
    input  logic                   rst,
    rename_group_if.dst            grp,
    input  rename_pkg::preg_t      prd     [`GROUP_WIDTH],  // final new dests
    input  rename_pkg::slot_mask_t tbl_we,                  // youngest-wins mask
    output rename_pkg::preg_t      tbl_rs1 [`GROUP_WIDTH],
    output rename_pkg::preg_t      tbl_rs2 [`GROUP_WIDTH],
    output rename_pkg::preg_t      tbl_rd  [`GROUP_WIDTH]
);

    // speculative arch -> phys map
    rename_pkg::preg_t rat [`NUM_ARF];

    // twelve async read ports, pre-bypass values
    always_comb begin
        for (int i = 0; i < `GROUP_WIDTH; i++) begin
            tbl_rs1[i] = rat[grp.rs1[i]];
            tbl_rs2[i] = rat[grp.rs2[i]];
            tbl_rd[i]  = rat[grp.rd[i]];   // old mapping before waw fixup
        end
    end

    // four write ports
    // mask guarantees distinct rd among enabled slots
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int a = 0; a < `NUM_ARF; a++)
                rat[a] <= rename_pkg::preg_t'(a);   // identity map
        end else begin
            for (int i = 0; i < `GROUP_WIDTH; i++) begin
                if (tbl_we[i])
                    rat[grp.rd[i]] <= prd[i];
            end
        end
    end

endmodule

//--- rtl/free_list_ptrs.sv
`timescale 1ns/10ps
`include "rename_consts.svh"

module free_list_ptrs (
    input  logic                   clk,
    input  logic                   rst,
    rename_group_if.dst            grp,
    input  rename_pkg::slot_mask_t retire_v,  // one release per set bit
    output rename_pkg::fl_ptr_t    head,      // next entry to allocate
    output rename_pkg::fl_ptr_t    tail       // next entry to fill
);

    logic [2:0] alloc_cnt;  // 0..4 dests this cycle
    logic [2:0] rel_cnt;    // 0..4 releases this cycle

    function automatic logic [2:0] ones(input rename_pkg::slot_mask_t m);
        logic [2:0] n;
        n = '0;
        for (int i = 0; i < `GROUP_WIDTH; i++)
            n = n + 3'(m[i]);
        return n;
    endfunction

    assign alloc_cnt = ones(grp.rd_v);
    assign rel_cnt   = ones(retire_v);

    // both pointers wrap at NUM_PRF
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head <= '0;
            tail <= rename_pkg::fl_ptr_t'(`NUM_PRF - `NUM_ARF);  // 32 regs free out of reset
        end else begin
            head <= head + rename_pkg::fl_ptr_t'(alloc_cnt);
            tail <= tail + rename_pkg::fl_ptr_t'(rel_cnt);
        end
    end

endmodule

//--- rtl/free_list_store.sv
`timescale 1ns/10ps
`include "rename_consts.svh"

module free_list_store (
    input  logic                   clk,
    input  logic                   rst,
    input  rename_pkg::fl_ptr_t    head,
    input  rename_pkg::fl_ptr_t    tail,
    input  rename_pkg::slot_mask_t retire_v,
    input  rename_pkg::preg_t      retire_preg [`RETIRE_WIDTH],  // old pregs being freed
    output rename_pkg::preg_t      head_preg   [`GROUP_WIDTH]
);

    rename_pkg::preg_t   fl_mem  [`NUM_PRF];      // circular list of free pregs
    rename_pkg::fl_ptr_t wr_addr [`RETIRE_WIDTH];  // packed slot per release

    // four consecutive entries from head, wraps past 63
    always_comb begin
        for (int k = 0; k < `GROUP_WIDTH; k++)
            head_preg[k] = fl_mem[head + rename_pkg::fl_ptr_t'(k)];
    end

    // rank among set retire_v bits gives offset from tail
    always_comb begin : pack_p
        rename_pkg::fl_ptr_t ptr;
        ptr = tail;
        for (int k = 0; k < `RETIRE_WIDTH; k++) begin
            wr_addr[k] = ptr;
            ptr = ptr + rename_pkg::fl_ptr_t'(retire_v[k]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // entry i holds 32+i, upper half is empty space
            for (int e = 0; e < `NUM_PRF; e++)
                fl_mem[e] <= rename_pkg::preg_t'(`NUM_ARF + e);
        end else begin
            for (int k = 0; k < `RETIRE_WIDTH; k++) begin
                if (retire_v[k])
                    fl_mem[wr_addr[k]] <= retire_preg[k];  // addrs distinct by packing
            end
        end
    end

endmodule

//--- rtl/rename_stage.sv
`timescale 1ns/10ps
`include "rename_consts.svh"

module rename_stage (
    input  logic                   clk,
    input  logic                   rst,
    // decoded group
    input  rename_pkg::areg_t      rs1 [`GROUP_WIDTH],
    input  rename_pkg::areg_t      rs2 [`GROUP_WIDTH],
    input  rename_pkg::areg_t      rd  [`GROUP_WIDTH],
    input  rename_pkg::slot_mask_t rs1_v,
    input  rename_pkg::slot_mask_t rs2_v,
    input  rename_pkg::slot_mask_t rd_v,
    // from retire
    input  rename_pkg::slot_mask_t retire_v,
    input  rename_pkg::preg_t      retire_preg [`RETIRE_WIDTH],
    // renamed group, same cycle
    output rename_pkg::preg_t      prs1   [`GROUP_WIDTH],
    output rename_pkg::preg_t      prs2   [`GROUP_WIDTH],
    output rename_pkg::preg_t      prd    [`GROUP_WIDTH],
    output rename_pkg::preg_t      preprd [`GROUP_WIDTH]
);

    rename_group_if grp ();

    rename_pkg::preg_t      tbl_rs1   [`GROUP_WIDTH];
    rename_pkg::preg_t      tbl_rs2   [`GROUP_WIDTH];
    rename_pkg::preg_t      tbl_rd    [`GROUP_WIDTH];
    rename_pkg::preg_t      head_preg [`GROUP_WIDTH];
    rename_pkg::slot_mask_t tbl_we;
    rename_pkg::fl_ptr_t    head;
    rename_pkg::fl_ptr_t    tail;

    // decode side of the group bundle
    assign grp.rs1   = rs1;
    assign grp.rs2   = rs2;
    assign grp.rd    = rd;
    assign grp.rs1_v = rs1_v;
    assign grp.rs2_v = rs2_v;
    assign grp.rd_v  = rd_v;

    rename_resolve u_rename_resolve (
        .grp       (grp),
        .tbl_rs1   (tbl_rs1),
        .tbl_rs2   (tbl_rs2),
        .tbl_rd    (tbl_rd),
        .head_preg (head_preg),
        .prs1      (prs1),
        .prs2      (prs2),
        .prd       (prd),
        .preprd    (preprd),
        .tbl_we    (tbl_we)
    );

    rename_map_table u_rename_map_table (
        .clk     (clk),
        .rst     (rst),
        .grp     (grp),
        .prd     (prd),     // resolved dests feed the writes
        .tbl_we  (tbl_we),
        .tbl_rs1 (tbl_rs1),
        .tbl_rs2 (tbl_rs2),
        .tbl_rd  (tbl_rd)
    );

    free_list_ptrs u_free_list_ptrs (
        .clk      (clk),
        .rst      (rst),
        .grp      (grp),
        .retire_v (retire_v),
        .head     (head),
        .tail     (tail)
    );

    free_list_store u_free_list_store (
        .clk         (clk),
        .rst         (rst),
        .head        (head),
        .tail        (tail),
        .retire_v    (retire_v),
        .retire_preg (retire_preg),
        .head_preg   (head_preg)
    );

endmodule

//--- tb/tb_rename.sv
`timescale 1ns/10ps
`include "rename_consts.svh"

module tb_rename;

    localparam int NUM_CYCLES = 2000;
    localparam int LIMIT      = NUM_CYCLES + NUM_CYCLES / 10;  // reset plus margin

    logic                   clk;
    logic                   rst;
    rename_pkg::areg_t      rs1 [`GROUP_WIDTH];
    rename_pkg::areg_t      rs2 [`GROUP_WIDTH];
    rename_pkg::areg_t      rd  [`GROUP_WIDTH];
    rename_pkg::slot_mask_t rs1_v;
    rename_pkg::slot_mask_t rs2_v;
    rename_pkg::slot_mask_t rd_v;
    rename_pkg::slot_mask_t retire_v;
    rename_pkg::preg_t      retire_preg [`RETIRE_WIDTH];
    rename_pkg::preg_t      prs1   [`GROUP_WIDTH];
    rename_pkg::preg_t      prs2   [`GROUP_WIDTH];
    rename_pkg::preg_t      prd    [`GROUP_WIDTH];
    rename_pkg::preg_t      preprd [`GROUP_WIDTH];

    integer seed;
    int     cyc = 0;

    // reference model
    rename_pkg::preg_t m_tbl [`NUM_ARF];  // arch -> phys
    rename_pkg::preg_t free_q [$];        // free list, head at front
    rename_pkg::preg_t pool_q [$];        // old mappings awaiting retire

    rename_stage u_rename_stage (
        .clk         (clk),
        .rst         (rst),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .rs1_v       (rs1_v),
        .rs2_v       (rs2_v),
        .rd_v        (rd_v),
        .retire_v    (retire_v),
        .retire_preg (retire_preg),
        .prs1        (prs1),
        .prs2        (prs2),
        .prd         (prd),
        .preprd      (preprd)
    );

    always #4 clk = ~clk;  // 8 ns period

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", LIMIT);
            $display("Some tests failed");
            $fatal(1, "timeout");
        end
    end

    // small index range so collisions are frequent
    function automatic rename_pkg::areg_t draw_areg();
        return rename_pkg::areg_t'({$random(seed)} % 8);
    endfunction

    task automatic check(input string name, input rename_pkg::preg_t exp,
                         input rename_pkg::preg_t act);
        if (exp !== act) begin
            $display("error %s expected %0d actual %0d", name, exp, act);
            $display("Some tests failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic drive_group();
        int nfree;
        int idx;
        nfree = free_q.size();
        for (int i = 0; i < `GROUP_WIDTH; i++) begin
            rs1[i] = draw_areg();
            rs2[i] = draw_areg();
            rd[i]  = draw_areg();
        end
        rs1_v = rename_pkg::slot_mask_t'($random(seed));
        rs2_v = rename_pkg::slot_mask_t'($random(seed));
        rd_v  = rename_pkg::slot_mask_t'($random(seed));
        for (int i = 0; i < `GROUP_WIDTH; i++) begin
            if (rd_v[i]) begin
                if (nfree == 0)
                    rd_v[i] = 1'b0;  // never ask for more than is free
                else
                    nfree--;
            end
        end
        // random subset of outstanding old mappings
        for (int k = 0; k < `RETIRE_WIDTH; k++) begin
            if (pool_q.size() > 0 && {$random(seed)} % 2 == 1) begin
                idx = int'({$random(seed)} % pool_q.size());
                retire_preg[k] = pool_q[idx];
                pool_q.delete(idx);
                retire_v[k] = 1'b1;
            end else begin
                retire_v[k]    = 1'b0;
                retire_preg[k] = rename_pkg::preg_t'($random(seed));  // junk on idle slot
            end
        end
    endtask

    task automatic check_group();
        rename_pkg::preg_t new_p [`GROUP_WIDTH];
        rename_pkg::preg_t old_p [`GROUP_WIDTH];
        rename_pkg::preg_t exp1;
        rename_pkg::preg_t exp2;
        int rank;
        rank = 0;
        for (int i = 0; i < `GROUP_WIDTH; i++) begin
            new_p[i] = rd_v[i] ? free_q[rank] : '0;  // k-th valid dest gets head+k
            if (rd_v[i])
                rank++;
        end
        for (int i = 0; i < `GROUP_WIDTH; i++) begin
            exp1     = m_tbl[rs1[i]];
            exp2     = m_tbl[rs2[i]];
            old_p[i] = m_tbl[rd[i]];
            for (int j = 0; j < i; j++) begin
                if (rd_v[j]) begin  // later j is nearer, overrides
                    if (rd[j] == rs1[i]) exp1 = new_p[j];
                    if (rd[j] == rs2[i]) exp2 = new_p[j];
                    if (rd[j] == rd[i])  old_p[i] = new_p[j];
                end
            end
            if (rs1_v[i])
                check($sformatf("cycle %0d prs1 slot %0d", cyc, i), exp1, prs1[i]);
            if (rs2_v[i])
                check($sformatf("cycle %0d prs2 slot %0d", cyc, i), exp2, prs2[i]);
            if (rd_v[i]) begin
                check($sformatf("cycle %0d prd slot %0d", cyc, i), new_p[i], prd[i]);
                check($sformatf("cycle %0d preprd slot %0d", cyc, i), old_p[i], preprd[i]);
            end
        end
        // in-order writes leave the youngest mapping
        for (int i = 0; i < `GROUP_WIDTH; i++) begin
            if (rd_v[i]) begin
                m_tbl[rd[i]] = new_p[i];
                pool_q.push_back(old_p[i]);
            end
        end
        for (int n = 0; n < rank; n++)
            void'(free_q.pop_front());
        for (int k = 0; k < `RETIRE_WIDTH; k++) begin
            if (retire_v[k])
                free_q.push_back(retire_preg[k]);  // slot order at tail
        end
    endtask

    initial begin
        seed     = 32'h6b45f703;
        clk      = 1'b0;
        rst      = 1'b1;
        rs1_v    = '0;
        rs2_v    = '0;
        rd_v     = '0;
        retire_v = '0;
        for (int i = 0; i < `GROUP_WIDTH; i++) begin
            rs1[i] = '0;
            rs2[i] = '0;
            rd[i]  = '0;
        end
        for (int k = 0; k < `RETIRE_WIDTH; k++)
            retire_preg[k] = '0;
        for (int a = 0; a < `NUM_ARF; a++)
            m_tbl[a] = rename_pkg::preg_t'(a);  // identity after reset
        for (int p = `NUM_ARF; p < `NUM_PRF; p++)
            free_q.push_back(rename_pkg::preg_t'(p));
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int c = 0; c < NUM_CYCLES; c++) begin
            drive_group();
            #2;  // settle, well before the rising edge
            check_group();
            @(negedge clk);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

//--- project.f
+incdir+rtl
rtl/rename_pkg.sv
rtl/rename_group_if.sv
rtl/rename_resolve.sv
rtl/rename_map_table.sv
rtl/free_list_ptrs.sv
rtl/free_list_store.sv
rtl/rename_stage.sv
tb/tb_rename.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rename stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_rename -o tb_rename_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/tb_rename_sim > sim.log 2>&1
run_status=$?

if grep -q "Some tests failed" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status, see sim.log"
    exit 1
fi
echo "simulation passed"
exit 0
